// ==== files.f ====
logic/cpu_pkg.sv
logic/cpu_ctl_if.sv
logic/pm.sv
logic/pd.sv
logic/pr.sv
logic/pa.sv
logic/cpu.sv
verif/cpu_properties.sv
verif/cpu_checker.sv
verif/tb_cpu.sv

// ==== Makefile ====
SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = tb_cpu
FILELIST = files.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "test failed" $(LOG)
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verif/tb_cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;

	localparam int n_tests = 20;
	localparam int test_cycles = 60;
	localparam int max_latency = 4;
	localparam int clk_period = 8;
	localparam int watchdog_ns = n_tests * test_cycles * max_latency * clk_period;

	logic clk;
	logic rst_n = 1'b0;
	logic start_ = 1'b1;
	logic rok_ = 1'b1;
	logic [0:cpu_pkg::word_w-1] kl = '0;
	logic [0:cpu_pkg::word_w-1] rdt_ = '1;
	logic [0:cpu_pkg::word_w-1] dad_;
	logic [0:cpu_pkg::word_w-1] ddt_;
	logic [0:cpu_pkg::word_w-1] w;
	logic dr_;
	logic dw_;
	logic run;
	logic hlt_n_;
	logic awaria_;
	int tests_done;
	int fail_count;

	// Memory model with random latency
	logic [0:cpu_pkg::word_w-1] mem [0:255];
	logic [1:0] wait_left = 2'd0;
	logic [15:0] lfsr = 16'd50;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[14:0], lfsr[15]};
			lfsr = lfsr_next(lfsr);
		end
		return val;
	endfunction

	function automatic logic is_legal(input logic [0:5] code);
		return code inside {cpu_pkg::op_lw, cpu_pkg::op_rw, cpu_pkg::op_aw,
			cpu_pkg::op_sw, cpu_pkg::op_nr, cpu_pkg::op_hlt};
	endfunction

	cpu i_cpu(.__clk(clk), .*);

	cpu_checker u_checker(.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// ------------------------------
	// Bus memory
	// ------------------------------

	always @(posedge clk) begin
		if (!rok_) begin
			rok_ <= 1'b1;
			rdt_ <= '1;
			wait_left <= 2'(rand_bits(2));
		end else if (!dr_ || !dw_) begin
			if (wait_left != 2'd0) begin
				wait_left <= wait_left - 2'd1;
			end else begin
				rok_ <= 1'b0;
				if (!dr_)
					rdt_ <= ~mem[8'(~dad_)];
				else
					mem[8'(~dad_)] = ~ddt_;
			end
		end
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired before all programs halted");
		$display("test failed");
		$finish;
	end

	// ------------------------------
	// Program generation and runs
	// ------------------------------

	initial begin
		int n_ins;
		logic [0:5] code;
		logic [0:cpu_pkg::word_w-1] arg;

		for (int a = 0; a < 256; a++)
			mem[a] = {a[7:0], a[7:0] ^ 8'h5a};
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		for (int t = 0; t < n_tests; t++) begin
			n_ins = 1 + int'(rand_bits(3));
			for (int i = 0; i <= n_ins; i++) begin
				if (i < n_ins) begin
					case (rand_bits(3) % 5)
						0: code = cpu_pkg::op_lw;
						1: code = cpu_pkg::op_rw;
						2: code = cpu_pkg::op_aw;
						3: code = cpu_pkg::op_sw;
						default: code = cpu_pkg::op_nr;
					endcase
					// Data area is 128..255
					if (code == cpu_pkg::op_lw || code == cpu_pkg::op_rw)
						arg = 16'd128 + rand_bits(7);
					else
						arg = rand_bits(16);
				end else begin
					code = cpu_pkg::op_hlt;
					arg = '0;
					if (t % 5 == 4) begin
						do
							code = 6'(rand_bits(6));
						while (is_legal(code));
					end
				end
				mem[2 * i] = {code, 1'b0, 3'(rand_bits(3)), 6'b0};
				mem[2 * i + 1] = arg;
			end
			@(posedge clk);
			kl <= '0;
			start_ <= 1'b0;
			@(posedge clk);
			start_ <= 1'b1;
			while (tests_done <= t)
				@(posedge clk);
			// Quiet bus expected while halted
			repeat (4) @(posedge clk);
		end
		$display("%0d tests run, %0d checks failed", tests_done, fail_count);
		if (fail_count == 0 && tests_done == n_tests)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/cpu_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_checker(
	input logic clk,
	input logic rst_n,
	input logic start_,
	input logic [0:cpu_pkg::word_w-1] kl,
	input logic dr_,
	input logic dw_,
	input logic rok_,
	input logic [0:cpu_pkg::word_w-1] dad_,
	input logic [0:cpu_pkg::word_w-1] ddt_,
	input logic [0:cpu_pkg::word_w-1] rdt_,
	input logic [0:cpu_pkg::word_w-1] w,
	input logic run,
	input logic hlt_n_,
	input logic awaria_,
	output int tests_done,
	output int fail_count
);

	// 0 stopped, 1 opcode, 2 argument, 3 operand, 4 halt lamps
	int stage;
	int test_errs;
	logic [0:cpu_pkg::word_w-1] regs [0:cpu_pkg::reg_n-1];
	logic [0:cpu_pkg::word_w-1] exp_ic;
	logic [0:cpu_pkg::word_w-1] arg;
	logic [0:cpu_pkg::word_w-1] data;
	logic [0:5] op;
	logic [0:2] rsel;
	logic illegal;
	logic alu_due;

	task automatic compare(input string what, input logic [0:15] exp, input logic [0:15] act);
		if (exp !== act) begin
			$display("CHECK FAILED test_%0d %s: expected %h, actual %h",
				tests_done, what, exp, act);
			test_errs++;
			fail_count++;
		end
	endtask

	task automatic flag_error(input string what);
		$display("test_%0d: %s", tests_done, what);
		test_errs++;
		fail_count++;
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::reg_n; i++)
				regs[i] = '0;
			stage = 0;
			test_errs = 0;
			tests_done = 0;
			fail_count = 0;
			exp_ic = '0;
			alu_due = 1'b0;
		end else if (alu_due) begin
			// Write-back cycle of an immediate op
			compare("W bus", regs[rsel], w);
			alu_due = 1'b0;
		end else if (!start_) begin
			exp_ic = kl;
			stage = 1;
		end else if (!rok_ && (!dr_ || !dw_)) begin
			data = ~rdt_;
			compare("run", 1'b1, run);
			case (stage)
				1: begin
					if (dr_)
						flag_error("opcode fetch was not a read");
					compare("opcode address", exp_ic, ~dad_);
					exp_ic = exp_ic + 16'd1;
					op = data[0:5];
					rsel = data[7:9];
					illegal = !(op inside {cpu_pkg::op_lw, cpu_pkg::op_rw, cpu_pkg::op_aw,
						cpu_pkg::op_sw, cpu_pkg::op_nr, cpu_pkg::op_hlt});
					stage = (op == cpu_pkg::op_hlt || illegal) ? 4 : 2;
				end
				2: begin
					compare("argument address", exp_ic, ~dad_);
					exp_ic = exp_ic + 16'd1;
					arg = data;
					if (op == cpu_pkg::op_aw)
						regs[rsel] = regs[rsel] + arg;
					else if (op == cpu_pkg::op_sw)
						regs[rsel] = regs[rsel] - arg;
					else if (op == cpu_pkg::op_nr)
						regs[rsel] = regs[rsel] & arg;
					stage = (op == cpu_pkg::op_lw || op == cpu_pkg::op_rw) ? 3 : 1;
					alu_due = (stage == 1);
				end
				3: begin
					compare("operand address", arg, ~dad_);
					if (op == cpu_pkg::op_lw) begin
						if (dr_)
							flag_error("LW operand access was not a read");
						regs[rsel] = data;
					end else begin
						if (dw_)
							flag_error("RW operand access was not a write");
						compare("RW data", regs[rsel], ~ddt_);
					end
					// Register value or loaded word on W
					compare("W bus", regs[rsel], w);
					stage = 1;
				end
				default: flag_error("bus transfer while the CPU is stopped");
			endcase
		end else if (stage == 4) begin
			compare("hlt_n_", '0, hlt_n_);
			compare("run", '0, run);
			compare("awaria_", !illegal, awaria_);
			$display("test_%0d finished with %0d errors", tests_done, test_errs);
			test_errs = 0;
			tests_done++;
			stage = 0;
		end else if (stage == 0 && (!dr_ || !dw_)) begin
			flag_error("bus request after the CPU halted");
		end
	end

endmodule

`default_nettype wire

// ==== verif/cpu_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu_properties(
	input logic clk,
	input logic rst_n,
	input logic dr_,
	input logic dw_,
	input logic rok_,
	input logic run,
	input logic hlt_n_,
	input logic awaria_,
	input cpu_pkg::phase_e state
);

	// Read and write never requested together
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n) dr_ || dw_)
		else $error("dr_ and dw_ low together");

	// Requests stay low until rok_
	a_read_held: assert property (@(posedge clk) disable iff (!rst_n) (!dr_ && rok_) |=> !dr_)
		else $error("dr_ released before rok_");
	a_write_held: assert property (@(posedge clk) disable iff (!rst_n) (!dw_ && rok_) |=> !dw_)
		else $error("dw_ released before rok_");

	a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
		(dr_ && dw_ && hlt_n_ && awaria_ && !run && state == cpu_pkg::ph_idle))
		else $error("outputs not inactive after reset");

endmodule

bind pm cpu_properties u_props(
	.clk(__clk),
	.rst_n(rst_n),
	.dr_(dr_),
	.dw_(dw_),
	.rok_(rok_),
	.run(run),
	.hlt_n_(hlt_n_),
	.awaria_(awaria_),
	.state(state)
);

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu(
	input logic __clk,
	input logic rst_n,

	// Control panel
	input logic start_,
	input logic [0:cpu_pkg::word_w-1] kl,
	output logic [0:cpu_pkg::word_w-1] w,
	output logic run,
	output logic hlt_n_,
	output logic awaria_,

	// System bus
	output logic dr_,
	output logic dw_,
	input logic rok_,
	output logic [0:cpu_pkg::word_w-1] dad_,
	output logic [0:cpu_pkg::word_w-1] ddt_,
	input logic [0:cpu_pkg::word_w-1] rdt_
);

	cpu_ctl_if ctl();

	logic [0:cpu_pkg::word_w-1] r_out;

	// ------------------------------
	// Sequencer and decoder
	// ------------------------------

	pm u_pm(
		.__clk(__clk),
		.rst_n(rst_n),
		.start_(start_),
		.rok_(rok_),
		.ctl(ctl.seq),
		.dr_(dr_),
		.dw_(dw_),
		.run(run),
		.hlt_n_(hlt_n_),
		.awaria_(awaria_)
	);

	pd u_pd(
		.__clk(__clk),
		.rst_n(rst_n),
		.rdt_(rdt_),
		.ctl(ctl.dec)
	);

	// ------------------------------
	// Datapath
	// ------------------------------

	pr u_pr(
		.__clk(__clk),
		.rst_n(rst_n),
		.ctl(ctl.regs),
		.w(w),
		.r_out(r_out)
	);

	pa u_pa(
		.__clk(__clk),
		.rst_n(rst_n),
		.kl(kl),
		.rdt_(rdt_),
		.r_out(r_out),
		.ctl(ctl.alu),
		.w(w),
		.dad_(dad_),
		.ddt_(ddt_)
	);

endmodule

`default_nettype wire

// ==== logic/pa.sv ====
`timescale 1ns/1ns
`default_nettype none

module pa(
	input logic __clk,
	input logic rst_n,
	input logic [0:cpu_pkg::word_w-1] kl,
	input logic [0:cpu_pkg::word_w-1] rdt_,
	input logic [0:cpu_pkg::word_w-1] r_out,
	cpu_ctl_if.alu ctl,
	output logic [0:cpu_pkg::word_w-1] w,
	output logic [0:cpu_pkg::word_w-1] dad_,
	output logic [0:cpu_pkg::word_w-1] ddt_
);

	logic [0:cpu_pkg::word_w-1] ic;
	logic [0:cpu_pkg::word_w-1] ar;
	logic [0:cpu_pkg::word_w-1] dt;
	logic [0:cpu_pkg::word_w-1] alu_res;

	// ------------------------------
	// IC and AR
	// ------------------------------

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			ic <= '0;
			ar <= '0;
		end else begin
			if (ctl.w_ic)
				ic <= kl;
			else if (ctl.icp1)
				ic <= ic + 1'b1;
			if (ctl.w_ar)
				ar <= ~rdt_;
		end
	end

	// Store data latched with the argument
	always_ff @(posedge __clk) begin
		if (ctl.w_ar)
			dt <= r_out;
	end

	// ------------------------------
	// ALU and W bus
	// ------------------------------

	always_comb begin
		case (ctl.alu_op)
			cpu_pkg::alu_add: alu_res = r_out + ar;
			cpu_pkg::alu_sub: alu_res = r_out - ar;
			cpu_pkg::alu_and: alu_res = r_out & ar;
			default: alu_res = ar;
		endcase
	end

	// Read data when nothing else drives W
	assign w = ctl.r_w ? r_out : (ctl.alu_w ? alu_res : ~rdt_);

	// Operand address in p3, instruction counter otherwise
	assign dad_ = ~(ctl.bus_ad ? ar : ic);
	assign ddt_ = ~dt;

endmodule

`default_nettype wire

// ==== logic/pr.sv ====
`timescale 1ns/1ns
`default_nettype none

module pr(
	input logic __clk,
	input logic rst_n,
	cpu_ctl_if.regs ctl,
	input logic [0:cpu_pkg::word_w-1] w,
	output logic [0:cpu_pkg::word_w-1] r_out
);

	// User registers r0..r7
	logic [0:cpu_pkg::word_w-1] user_r [0:cpu_pkg::reg_n-1];

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < cpu_pkg::reg_n; i++)
				user_r[i] <= '0;
		end else if (ctl.w_r) begin
			user_r[ctl.rsel] <= w;
		end
	end

	// Selected register, always visible
	assign r_out = user_r[ctl.rsel];

endmodule

`default_nettype wire

// ==== logic/pd.sv ====
`timescale 1ns/1ns
`default_nettype none

module pd(
	input logic __clk,
	input logic rst_n,
	input logic [0:cpu_pkg::word_w-1] rdt_,
	cpu_ctl_if.dec ctl
);

	logic [0:cpu_pkg::word_w-1] ir;

	// Instruction register, bus data is active low
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n)
			ir <= '0;
		else if (ctl.w_ir)
			ir <= ~rdt_;
	end

	// ------------------------------
	// Decode
	// ------------------------------

	assign ctl.op = cpu_pkg::op_e'(ir[0:5]);
	assign ctl.rsel = ir[7:9];

	always_comb begin
		ctl.illegal = 1'b0;
		case (ctl.op)
			cpu_pkg::op_lw: ctl.alu_op = cpu_pkg::alu_pass;
			cpu_pkg::op_rw: ctl.alu_op = cpu_pkg::alu_pass;
			cpu_pkg::op_aw: ctl.alu_op = cpu_pkg::alu_add;
			cpu_pkg::op_sw: ctl.alu_op = cpu_pkg::alu_sub;
			cpu_pkg::op_nr: ctl.alu_op = cpu_pkg::alu_and;
			cpu_pkg::op_hlt: ctl.alu_op = cpu_pkg::alu_pass;
			default: begin
				// Unlisted opcode
				ctl.alu_op = cpu_pkg::alu_pass;
				ctl.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/pm.sv ====
`timescale 1ns/1ns
`default_nettype none

module pm(
	input logic __clk,
	input logic rst_n,
	input logic start_,
	input logic rok_,
	cpu_ctl_if.seq ctl,
	output logic dr_,
	output logic dw_,
	output logic run,
	output logic hlt_n_,
	output logic awaria_
);

	cpu_pkg::phase_e state;
	logic start_q;
	logic ack;
	logic stop_op;
	logic stop_now;
	logic mem_op;
	logic fetch_ack;
	logic arg_ack;

	// Memory answered an outstanding request
	assign ack = ~rok_ & (~dr_ | ~dw_);

	assign stop_op = (ctl.op == cpu_pkg::op_hlt) | ctl.illegal;
	assign mem_op = (ctl.op == cpu_pkg::op_lw) | (ctl.op == cpu_pkg::op_rw);
	// Opcode is visible in the first cycle of p2
	assign stop_now = (state == cpu_pkg::ph_p2) & stop_op;

	// ------------------------------
	// Phase stepping
	// ------------------------------

	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= cpu_pkg::ph_idle;
			start_q <= 1'b0;
		end else begin
			start_q <= ~start_ & ((state == cpu_pkg::ph_idle) | (state == cpu_pkg::ph_halt));
			case (state)
				cpu_pkg::ph_idle, cpu_pkg::ph_halt: begin
					if (start_q)
						state <= cpu_pkg::ph_p1;
				end
				cpu_pkg::ph_p1: begin
					if (ack)
						state <= cpu_pkg::ph_p2;
				end
				cpu_pkg::ph_p2: begin
					if (stop_op)
						state <= cpu_pkg::ph_halt;
					else if (ack)
						state <= mem_op ? cpu_pkg::ph_p3 : cpu_pkg::ph_p4;
				end
				cpu_pkg::ph_p3: begin
					if (ack)
						state <= cpu_pkg::ph_p1;
				end
				cpu_pkg::ph_p4: state <= cpu_pkg::ph_p1;
				default: state <= cpu_pkg::ph_idle;
			endcase
		end
	end

	// ------------------------------
	// Bus strobes
	// ------------------------------

	// Request drops after the acknowledge, then rises again for the next phase
	always_ff @(posedge __clk or negedge rst_n) begin
		if (!rst_n) begin
			dr_ <= 1'b1;
			dw_ <= 1'b1;
		end else if (ack) begin
			dr_ <= 1'b1;
			dw_ <= 1'b1;
		end else if (dr_ & dw_) begin
			case (state)
				cpu_pkg::ph_p1: dr_ <= 1'b0;
				cpu_pkg::ph_p2: dr_ <= stop_op;
				cpu_pkg::ph_p3: begin
					dr_ <= (ctl.op == cpu_pkg::op_rw);
					dw_ <= (ctl.op != cpu_pkg::op_rw);
				end
				default: begin
					dr_ <= 1'b1;
					dw_ <= 1'b1;
				end
			endcase
		end
	end

	// Transfer strobes
	assign fetch_ack = (state == cpu_pkg::ph_p1) & ack;
	assign arg_ack = (state == cpu_pkg::ph_p2) & ack;

	assign ctl.w_ic = start_q;
	assign ctl.w_ir = fetch_ack;
	assign ctl.w_ar = arg_ack;
	assign ctl.icp1 = fetch_ack | arg_ack;
	assign ctl.bus_ad = (state == cpu_pkg::ph_p3);
	assign ctl.r_w = (state == cpu_pkg::ph_p3) & (ctl.op == cpu_pkg::op_rw);
	assign ctl.alu_w = (state == cpu_pkg::ph_p4);
	// LW writes straight from the read data at its acknowledge
	assign ctl.w_r = (state == cpu_pkg::ph_p4)
		| ((state == cpu_pkg::ph_p3) & (ctl.op == cpu_pkg::op_lw) & ack);

	// Panel lamps
	assign run = (state != cpu_pkg::ph_idle) & (state != cpu_pkg::ph_halt) & ~stop_now;
	assign hlt_n_ = ~((state == cpu_pkg::ph_halt) | stop_now);
	assign awaria_ = ~(ctl.illegal & ((state == cpu_pkg::ph_halt) | stop_now));

endmodule

`default_nettype wire

// ==== logic/cpu_ctl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface cpu_ctl_if;

	// Register transfer strobes
	logic w_ir;
	logic w_ar;
	logic w_r;
	logic icp1;
	logic w_ic;
	logic r_w;
	logic alu_w;
	logic bus_ad;

	// Decoded instruction fields
	cpu_pkg::op_e op;
	logic [0:$clog2(cpu_pkg::reg_n)-1] rsel;
	cpu_pkg::alu_e alu_op;
	logic illegal;

	modport seq(output w_ir, w_ar, w_r, icp1, w_ic, r_w, alu_w, bus_ad,
		input op, illegal);
	modport dec(input w_ir, output op, rsel, alu_op, illegal);
	modport regs(input w_r, rsel);
	modport alu(input w_ar, icp1, w_ic, r_w, alu_w, bus_ad, alu_op);

endinterface

`default_nettype wire

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	// ------------------------------
	// Word and register file sizes
	// ------------------------------

	localparam int word_w = 16;
	localparam int reg_n = 8;

	// ------------------------------
	// Opcodes
	// ------------------------------

	// Bits 0:5 of the opcode word, in octal as on the console
	typedef enum logic [0:5] {
		op_lw = 6'o20,
		op_rw = 6'o24,
		op_aw = 6'o40,
		op_sw = 6'o42,
		op_nr = 6'o46,
		op_hlt = 6'o73
	} op_e;

	// ------------------------------
	// Sequencer phases
	// ------------------------------

	typedef enum logic [2:0] {
		ph_idle,
		ph_p1,
		ph_p2,
		ph_p3,
		ph_p4,
		ph_halt
	} phase_e;

	// Register operand against the argument word
	typedef enum logic [1:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_pass
	} alu_e;

endpackage

`default_nettype wire
